/* filelist.f */
+incdir+include
verilog/fc_pkg.sv
verilog/fc_write_if.sv
verilog/fc_read_if.sv
verilog/fc_msg_decoder.sv
verilog/fc_param_store.sv
verilog/fc_mac_engine.sv
verilog/fc_layer_top.sv
verification/fc_layer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FC layer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module fc_layer_tb -o fc_layer_sim

output=$(./obj_dir/fc_layer_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

/* verification/fc_layer_tb.sv */
//========================================
// Table-driven testbench for fc_layer_top
// Expected outputs come from a 12-bit wrap model
//========================================

`include "fc_macros.svh"

module fc_layer_tb;

  localparam int IN      = `FC_INPUT_CHANNEL;
  localparam int OUT     = `FC_OUTPUT_CHANNEL;
  localparam int TIMEOUT = 100;
  localparam int NCASE   = 4;
  localparam logic [11:0] EARLY_BIAS = 12'h5A5;

  // One stimulus row, arrays listed highest index first
  typedef struct packed {
    logic [IN-1:0][OUT-1:0][11:0] w;
    logic [OUT-1:0][11:0]         b;
    logic [IN-1:0][11:0]          a;
    logic [3:0]                   batch;
    logic                         load_params;
    logic                         oor;
    logic                         gap;
    logic                         early;
  } case_t;

  logic        clk;
  logic        reset;
  logic        istream_val;
  logic        istream_rdy;
  logic [31:0] istream_msg;
  logic        ostream_val;
  logic        ostream_rdy;
  logic [31:0] ostream_msg;

  case_t       cases [NCASE];
  // Reference copy of what the layer should hold
  logic [11:0] m_w [IN][OUT];
  logic [11:0] m_b [OUT];
  logic [11:0] m_a [IN];
  logic [3:0]  m_batch;
  int          errors;
  int          checks;
  bit          timed_out;

  fc_layer_top UUT (
    .clk         (clk),
    .reset       (reset),
    .istream_val (istream_val),
    .istream_rdy (istream_rdy),
    .istream_msg (istream_msg),
    .ostream_val (ostream_val),
    .ostream_rdy (ostream_rdy),
    .ostream_msg (ostream_msg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //========================================
  // Message builders and reference model
  //========================================
  function automatic logic [31:0] weight_msg(input int i, input int o, input logic [11:0] v);
    return {2'd0, 10'(i), 8'(o), v};
  endfunction

  function automatic logic [31:0] bias_msg(input int o, input logic [11:0] v);
    return {2'd1, 8'(o), 10'd0, v};
  endfunction

  function automatic logic [31:0] input_msg(input int b, input int i, input logic [11:0] v);
    return {2'd2, 4'(b), 10'(i), 4'd0, v};
  endfunction

  // Bias plus wrapped dot product, sign-extended to 18 bits
  function automatic logic [31:0] expect_msg(input int o);
    logic [23:0] prod;
    logic [11:0] sum;
    sum = m_b[o];
    for (int i = 0; i < IN; i++) begin
      prod = m_a[i] * m_w[i][o];
      sum  = sum + prod[11:0];
    end
    return {2'd3, m_batch, 8'(o), {6{sum[11]}}, sum};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  //========================================
  // Input stream
  //========================================
  task automatic send_msg(input logic [31:0] msg);
    bit done;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done && !timed_out; n++) begin
      @(negedge clk);
      istream_val = 1'b1;
      istream_msg = msg;
      #1;
      if (istream_rdy) begin
        @(posedge clk);
        done = 1'b1;
      end
    end
    if (!done && !timed_out) begin
      $display("Timeout: istream_rdy stayed low for %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_weight(input int i, input int o, input logic [11:0] v);
    send_msg(weight_msg(i, o, v));
    m_w[i][o] = v;
  endtask

  task automatic send_bias(input int o, input logic [11:0] v);
    send_msg(bias_msg(o, v));
    m_b[o] = v;
  endtask

  task automatic send_input(input int b, input int i, input logic [11:0] v);
    send_msg(input_msg(b, i, v));
    m_a[i]  = v;
    m_batch = 4'(b);
  endtask

  // Accepted by the layer but must leave the model untouched
  task automatic send_discarded();
    // Input index 4 would alias onto 0 if truncated
    send_msg(weight_msg(4, 0, 12'h777));
    send_msg(weight_msg(1, 2, 12'h777));
    send_msg(bias_msg(2, 12'h777));
    send_msg(input_msg(15, 4, 12'h777));
    send_msg({2'd3, 4'd7, 8'd1, 18'h3FFFF});
  endtask

  //========================================
  // Output stream
  //========================================
  task automatic collect_outputs(input bit gap, input bit early);
    logic [31:0] exp_msg [OUT];
    logic [31:0] held_msg;
    bit          held;
    int          o;
    int          first_at;
    for (int j = 0; j < OUT; j++) begin
      exp_msg[j] = expect_msg(j);
    end
    held     = 1'b0;
    held_msg = '0;
    o        = 0;
    first_at = -1;
    // Negedge n comes after the n-th edge past the last input
    for (int n = 0; n < TIMEOUT && o < OUT; n++) begin
      @(negedge clk);
      // Next-batch bias offered while the vector is busy
      istream_val = early;
      istream_msg = bias_msg(1, EARLY_BIAS);
      ostream_rdy = gap ? ($urandom % 3 != 0) : 1'b1;
      #1;
      check_val("istream_rdy", 0, istream_rdy);
      if (held) begin
        assert (ostream_val) else begin
          $display("Output message withdrawn before acceptance at t=%0t", $time);
          errors++;
        end
        check_val("ostream_msg held", held_msg, ostream_msg);
      end
      if (ostream_val && first_at < 0) begin
        first_at = n;
        check_val("ostream_val latency", IN + 2, first_at);
      end
      if (ostream_val && ostream_rdy) begin
        check_val("ostream_msg", exp_msg[o], ostream_msg);
        o++;
        held = 1'b0;
      end else begin
        held     = ostream_val;
        held_msg = ostream_msg;
      end
    end
    if (o < OUT) begin
      $display("Timeout: only %0d of %0d output messages arrived", o, OUT);
      timed_out = 1'b1;
    end else begin
      @(negedge clk);
      istream_val = 1'b0;
      ostream_rdy = 1'b0;
      #1;
      check_val("istream_rdy", 1, istream_rdy);
    end
  endtask

  task automatic run_case(input case_t tc);
    if (tc.load_params) begin
      for (int i = 0; i < IN; i++) begin
        for (int o = 0; o < OUT; o++) begin
          send_weight(i, o, tc.w[i][o]);
        end
      end
      for (int o = 0; o < OUT; o++) begin
        send_bias(o, tc.b[o]);
      end
    end
    if (tc.oor) begin
      send_discarded();
    end
    for (int i = 0; i < IN; i++) begin
      send_input(tc.batch, i, tc.a[i]);
    end
    if (!timed_out) begin
      collect_outputs(tc.gap, tc.early);
    end
    if (tc.early) begin
      send_bias(1, EARLY_BIAS);
    end
    @(negedge clk);
    istream_val = 1'b0;
  endtask

  //========================================
  // Main sequence
  //========================================
  initial begin
    int errs_before;
    void'($urandom(97661));
    reset       = 1'b1;
    istream_val = 1'b0;
    istream_msg = '0;
    ostream_rdy = 1'b0;
    errors      = 0;
    checks      = 0;
    timed_out   = 1'b0;
    m_batch     = '0;
    for (int i = 0; i < IN; i++) begin
      m_a[i] = '0;
      for (int o = 0; o < OUT; o++) begin
        m_w[i][o] = '0;
      end
    end
    for (int o = 0; o < OUT; o++) begin
      m_b[o] = '0;
    end

    // Small values, then overflow, then kept weights, then mixed signs
    cases[0] = '{w: {12'd6, 12'd5, 12'd4, 12'd3, 12'd2, 12'd1},
                 b: {12'd20, 12'd10}, a: {12'd3, 12'd2, 12'd1},
                 batch: 4'd5, load_params: 1'b1, oor: 1'b0, gap: 1'b0, early: 1'b0};
    cases[1] = '{w: {12'hFF0, 12'h7FF, 12'h9C4, 12'h800, 12'h0AB, 12'hFFF},
                 b: {12'hF00, 12'h100}, a: {12'h002, 12'h003, 12'hFFF},
                 batch: 4'd9, load_params: 1'b1, oor: 1'b0, gap: 1'b1, early: 1'b1};
    cases[2] = '{w: '0, b: '0, a: {12'h010, 12'h020, 12'h7FF},
                 batch: 4'd3, load_params: 1'b0, oor: 1'b1, gap: 1'b1, early: 1'b0};
    cases[3] = '{w: {12'd7, 12'd0, 12'hFFE, 12'd1, 12'd3, 12'h400},
                 b: {12'd0, 12'hFFF}, a: {12'd5, 12'h800, 12'd4},
                 batch: 4'd14, load_params: 1'b1, oor: 1'b0, gap: 1'b1, early: 1'b0};

    repeat (8) @(negedge clk);
    reset = 1'b0;
    #1;
    check_val("istream_rdy", 1, istream_rdy);
    check_val("ostream_val", 0, ostream_val);
    $display("Reset case: %s", (errors == 0) ? "pass" : "fail");

    for (int r = 0; r < NCASE && !timed_out; r++) begin
      errs_before = errors;
      run_case(cases[r]);
      $display("Case %0d batch %0d: %s", r, cases[r].batch,
               (errors == errs_before && !timed_out) ? "pass" : "fail");
    end

    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/fc_layer_top.sv */
//========================================
// FC layer top with val/rdy streams
// One input vector is buffered at a time
//========================================

`include "fc_macros.svh"

module fc_layer_top import fc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  input  logic                  istream_val,
  output logic                  istream_rdy,
  input  logic [`FC_MSG_W-1:0]  istream_msg,

  output logic                  ostream_val,
  input  logic                  ostream_rdy,
  output logic [`FC_MSG_W-1:0]  ostream_msg
);

  fc_write_if wr_bus ();
  fc_read_if  rd_bus ();

  // Message decode into write strobes
  fc_msg_decoder u_decoder (
    .istream_val (istream_val),
    .istream_rdy (istream_rdy),
    .istream_msg (istream_msg),
    .wr          (wr_bus.decoder)
  );

  fc_param_store u_store (
    .clk   (clk),
    .reset (reset),
    .wr    (wr_bus.store),
    .rd    (rd_bus.store)
  );

  // MAC and output stream
  fc_mac_engine u_engine (
    .clk         (clk),
    .reset       (reset),
    .rd          (rd_bus.engine),
    .ostream_val (ostream_val),
    .ostream_rdy (ostream_rdy),
    .ostream_msg (ostream_msg)
  );

endmodule

/* verilog/fc_mac_engine.sv */
//========================================
// One MAC per output channel plus serializer
// All sums wrap at 12 bits
//========================================

`include "fc_macros.svh"

module fc_mac_engine import fc_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  fc_read_if.engine             rd,
  output logic                  ostream_val,
  input  logic                  ostream_rdy,
  output logic [`FC_MSG_W-1:0]  ostream_msg
);

  localparam int EXT_W = `FC_OUT_VALUE_W - `FC_VALUE_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACCUM,
    S_BIAS,
    S_SEND
  } state_e;

  state_e    state;
  in_idx_t   in_cnt;
  out_idx_t  out_cnt;
  fc_value_t acc [`FC_OUTPUT_CHANNEL];
  fc_value_t prod [`FC_OUTPUT_CHANNEL];
  fc_value_t sel_value;
  out_msg_t  out_msg;
  logic      out_xfer;
  logic      last_out;

  assign out_xfer = ostream_val && ostream_rdy;
  assign last_out = (out_cnt == out_idx_t'(`FC_OUTPUT_CHANNEL - 1));

  //========================================
  // FSM and counters
  //========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      in_cnt  <= '0;
      out_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          // Idle cycle doubles as the accumulator load
          if (rd.vector_full) begin
            state  <= S_ACCUM;
            in_cnt <= '0;
          end
        end
        S_ACCUM: begin
          if (in_cnt == in_idx_t'(`FC_INPUT_CHANNEL - 1)) begin
            state  <= S_BIAS;
            in_cnt <= '0;
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        S_BIAS: begin
          state   <= S_SEND;
          out_cnt <= '0;
        end
        S_SEND: begin
          if (out_xfer) begin
            if (last_out) begin
              state   <= S_IDLE;
              out_cnt <= '0;
            end else begin
              out_cnt <= out_cnt + 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign rd.rd_in_idx = in_cnt;

  //========================================
  // Multiply-accumulate
  //========================================
  // Products keep their low 12 bits only
  always_comb begin
    for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
      prod[j] = rd.rd_act * rd.rd_weight[j];
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
      if (state == S_IDLE) begin
        acc[j] <= '0;
      end else if (state == S_ACCUM) begin
        acc[j] <= acc[j] + prod[j];
      end else if (state == S_BIAS) begin
        acc[j] <= acc[j] + rd.bias[j];
      end
    end
  end

  //========================================
  // Output serializer
  //========================================
  always_comb begin
    sel_value = acc[0];
    for (int j = 1; j < `FC_OUTPUT_CHANNEL; j++) begin
      if (out_cnt == out_idx_t'(j)) begin
        sel_value = acc[j];
      end
    end
  end

  // Held stable by the registers behind it until accepted
  assign out_msg.kind    = MSG_OUTPUT;
  assign out_msg.batch   = rd.batch_idx;
  assign out_msg.channel = out_cnt;
  assign out_msg.value   = {{EXT_W{sel_value[`FC_VALUE_W-1]}}, sel_value};

  assign ostream_val = (state == S_SEND);
  assign ostream_msg = out_msg;

  // Frees the input vector on the last acceptance
  assign rd.vec_release = out_xfer && last_out;

endmodule

/* verilog/fc_param_store.sv */
//========================================
// Weights, biases and one input vector
// Weights and biases survive a vector release
//========================================

`include "fc_macros.svh"

module fc_param_store import fc_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  fc_write_if.store wr,
  fc_read_if.store  rd
);

  localparam int CNT_W = $clog2(`FC_INPUT_CHANNEL + 1);

  fc_value_t weight_mem [`FC_INPUT_CHANNEL][`FC_OUTPUT_CHANNEL];
  fc_value_t bias_mem   [`FC_OUTPUT_CHANNEL];
  fc_value_t act_mem    [`FC_INPUT_CHANNEL];

  logic [CNT_W-1:0] input_count;
  logic             vector_full;
  batch_idx_t       batch_reg;

  //========================================
  // Parameter and activation writes
  //========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `FC_INPUT_CHANNEL; i++) begin
        act_mem[i] <= '0;
        for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
          weight_mem[i][j] <= '0;
        end
      end
      for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
        bias_mem[j] <= '0;
      end
    end else begin
      for (int i = 0; i < `FC_INPUT_CHANNEL; i++) begin
        if (wr.input_wen && wr.in_idx == in_idx_t'(i)) begin
          act_mem[i] <= wr.value;
        end
        for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
          if (wr.weight_wen && wr.in_idx == in_idx_t'(i) && wr.out_idx == out_idx_t'(j)) begin
            weight_mem[i][j] <= wr.value;
          end
        end
      end
      for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
        if (wr.bias_wen && wr.out_idx == out_idx_t'(j)) begin
          bias_mem[j] <= wr.value;
        end
      end
    end
  end

  //========================================
  // Input count and full flag
  //========================================
  // Repeated input indices still count toward a full vector
  always_ff @(posedge clk) begin
    if (reset) begin
      input_count <= '0;
      vector_full <= 1'b0;
      batch_reg   <= '0;
    end else if (rd.vec_release) begin
      input_count <= '0;
      vector_full <= 1'b0;
    end else if (wr.input_wen) begin
      input_count <= input_count + 1'b1;
      batch_reg   <= wr.batch_idx;
      if (input_count == CNT_W'(`FC_INPUT_CHANNEL - 1)) begin
        vector_full <= 1'b1;
      end
    end
  end

  assign wr.vector_full = vector_full;
  assign rd.vector_full = vector_full;
  assign rd.batch_idx   = batch_reg;

  // Combinational read port for the engine
  assign rd.rd_act = act_mem[rd.rd_in_idx];

  always_comb begin
    for (int j = 0; j < `FC_OUTPUT_CHANNEL; j++) begin
      rd.rd_weight[j] = weight_mem[rd.rd_in_idx][j];
      rd.bias[j]      = bias_mem[j];
    end
  end

endmodule

/* verilog/fc_msg_decoder.sv */
//========================================
// Input message decoder, purely combinational
// Out-of-range and output-kind messages are dropped
//========================================

`include "fc_macros.svh"

module fc_msg_decoder import fc_pkg::*; (
  input  logic                  istream_val,
  output logic                  istream_rdy,
  input  logic [`FC_MSG_W-1:0]  istream_msg,
  fc_write_if.decoder           wr
);

  msg_kind_e  kind;
  logic       xfer;

  // Raw index fields before range checks
  logic [9:0] w_in_raw;
  logic [7:0] w_out_raw;
  logic [7:0] b_out_raw;
  logic [9:0] i_in_raw;

  logic       w_ok;
  logic       b_ok;
  logic       i_ok;

  assign kind = msg_kind_e'(istream_msg[31:30]);

  // Accept anything while the vector buffer has room
  assign istream_rdy = !wr.vector_full;
  assign xfer        = istream_val && istream_rdy;

  //========================================
  // Field extraction
  //========================================
  assign w_in_raw  = istream_msg[29:20];
  assign w_out_raw = istream_msg[19:12];
  assign b_out_raw = istream_msg[29:22];
  assign i_in_raw  = istream_msg[25:16];

  assign w_ok = (w_in_raw < `FC_INPUT_CHANNEL) && (w_out_raw < `FC_OUTPUT_CHANNEL);
  assign b_ok = (b_out_raw < `FC_OUTPUT_CHANNEL);
  assign i_ok = (i_in_raw < `FC_INPUT_CHANNEL);

  // Index buses, only meaningful alongside a strobe
  assign wr.in_idx    = (kind == MSG_WEIGHT) ? in_idx_t'(w_in_raw) : in_idx_t'(i_in_raw);
  assign wr.out_idx   = (kind == MSG_BIAS) ? b_out_raw : w_out_raw;
  assign wr.batch_idx = istream_msg[29:26];
  assign wr.value     = istream_msg[`FC_VALUE_W-1:0];

  //========================================
  // Write strobes
  //========================================
  // At most one fires, and output-kind messages raise none
  assign wr.weight_wen = xfer && (kind == MSG_WEIGHT) && w_ok;
  assign wr.bias_wen   = xfer && (kind == MSG_BIAS) && b_ok;
  assign wr.input_wen  = xfer && (kind == MSG_INPUT) && i_ok;

endmodule

/* verilog/fc_read_if.sv */
//========================================
// MAC engine access to the store
// Read data is combinational from rd_in_idx
//========================================

`include "fc_macros.svh"

interface fc_read_if import fc_pkg::*; ();

  logic       vector_full;
  batch_idx_t batch_idx;

  // Row select driven by the engine
  in_idx_t    rd_in_idx;

  // Activation and weight row at rd_in_idx
  fc_value_t                            rd_act;
  fc_value_t [`FC_OUTPUT_CHANNEL-1:0]   rd_weight;

  // Full bias array
  fc_value_t [`FC_OUTPUT_CHANNEL-1:0]   bias;

  // Frees the input vector after the last output
  logic       vec_release;

  modport store (
    output vector_full, batch_idx,
    input  rd_in_idx,
    output rd_act, rd_weight, bias,
    input  vec_release
  );

  modport engine (
    input  vector_full, batch_idx,
    output rd_in_idx,
    input  rd_act, rd_weight, bias,
    output vec_release
  );

endinterface

/* verilog/fc_write_if.sv */
//========================================
// Decoded write requests into the store
// Strobes are one cycle, indices pre-checked
//========================================

`include "fc_macros.svh"

interface fc_write_if import fc_pkg::*; ();

  logic       weight_wen;
  logic       bias_wen;
  logic       input_wen;
  in_idx_t    in_idx;
  out_idx_t   out_idx;
  batch_idx_t batch_idx;
  fc_value_t  value;

  // Vector buffer holds a complete input set
  logic       vector_full;

  modport decoder (
    output weight_wen, bias_wen, input_wen,
    output in_idx, out_idx, batch_idx, value,
    input  vector_full
  );

  modport store (
    input  weight_wen, bias_wen, input_wen,
    input  in_idx, out_idx, batch_idx, value,
    output vector_full
  );

endinterface

/* verilog/fc_pkg.sv */
//========================================
// Shared types for the FC layer
// Output message packs to exactly 32 bits
//========================================

`include "fc_macros.svh"

package fc_pkg;

  // Top two bits of every stream message
  typedef enum logic [1:0] {
    MSG_WEIGHT = 2'd0,
    MSG_BIAS   = 2'd1,
    MSG_INPUT  = 2'd2,
    MSG_OUTPUT = 2'd3
  } msg_kind_e;

  // Weight, bias, activation or partial sum
  typedef logic [`FC_VALUE_W-1:0] fc_value_t;

  // Input index just wide enough for the channel count
  localparam int IN_IDX_W = (`FC_INPUT_CHANNEL > 1) ? $clog2(`FC_INPUT_CHANNEL) : 1;
  typedef logic [IN_IDX_W-1:0] in_idx_t;

  // Output index matches the channel field of the message
  typedef logic [7:0] out_idx_t;

  typedef logic [3:0] batch_idx_t;

  //========================================
  // Output message, MSB first
  //========================================
  typedef struct packed {
    msg_kind_e                   kind;
    batch_idx_t                  batch;
    out_idx_t                    channel;
    logic [`FC_OUT_VALUE_W-1:0]  value;
  } out_msg_t;

endpackage

/* include/fc_macros.svh */
//========================================
// Channel counts and field widths
// Value width must stay 12 and fit the message layout
//========================================

`ifndef FC_MACROS_SVH
`define FC_MACROS_SVH

// Activations per input vector
`define FC_INPUT_CHANNEL 3

// Output channels, at most 256 for the channel field
`define FC_OUTPUT_CHANNEL 2

// Datapath and message widths
`define FC_VALUE_W 12
`define FC_OUT_VALUE_W 18
`define FC_MSG_W 32

`endif
